// File: include/bus_bridge_settings.svh
// bus bridge width and frame constants, included by the RTL and the testbench
`ifndef BUS_BRIDGE_SETTINGS_SVH
`define BUS_BRIDGE_SETTINGS_SVH

// cpu address and data width
`define BUS_WIDTH 32

// width of uo_out, uio_in and uio_out
`define PIN_WIDTH 8

// clock cycles in one bus frame
//   0      step
//   1..4   address and write data bytes
//   5      write flag
//   6..9   read bytes
`define FRAME_PHASES 10

`define RESET_PC 0  // first fetch address

`endif

// File: src/bus_bridge_pkg.sv
// shared types and opcodes of the bus bridge, referenced by scoped name from the RTL
`include "bus_bridge_settings.svh"

package bus_bridge_pkg;

  // one bus word, used for address, data and instruction
  typedef logic [`BUS_WIDTH-1:0] word_t;

  typedef logic [`PIN_WIDTH-1:0] pin_byte_t;  // one pin group value

  // frame phase, 0 to FRAME_PHASES-1
  typedef logic [3:0] phase_t;

  typedef logic [1:0] byte_sel_t;  // byte lane of a word, lsb first

  // cpu sequencing
  typedef enum logic {
    CPU_FETCH,  // read instruction at pc
    CPU_STORE   // write accumulator to the sta target
  } cpu_state_e;

  // instruction layout
  //   [31:28] opcode
  //   [27:0]  immediate, zero extended
  localparam logic [3:0] OP_LDI  = 4'd0;  // acc = imm
  localparam logic [3:0] OP_ADDI = 4'd1;  // acc = acc + imm
  localparam logic [3:0] OP_STA  = 4'd2;  // mem[imm] = acc
  localparam logic [3:0] OP_JMP  = 4'd3;  // pc = imm

  localparam int OPCODE_MSB = 31;
  localparam int OPCODE_LSB = 28;
  localparam int IMM_WIDTH  = 28;

endpackage

// File: src/cpu_bus_if.sv
// one cpu bus transaction between the cpu core and the bridge datapath
`timescale 1ns/1ns

interface cpu_bus_if;

  // driven by the cpu, held between step pulses
  bus_bridge_pkg::word_t addr;
  bus_bridge_pkg::word_t wdata;
  logic                  write;

  // driven by the bridge
  bus_bridge_pkg::word_t rdata;  // valid when step is high
  logic                  step;   // one cycle, ends the frame

  modport cpu (
    output addr,
    output wdata,
    output write,
    input  rdata,
    input  step
  );

  modport bridge (
    input  addr,
    input  wdata,
    input  write,
    output rdata,
    output step
  );

endinterface

// File: src/bus_phase_ctrl.sv
// frame phase counter of the bus bridge, decodes the byte select and the phase strobes
`timescale 1ns/1ns
`include "bus_bridge_settings.svh"

module bus_phase_ctrl (
  input  logic                      clk,
  input  logic                      reset,
  output bus_bridge_pkg::byte_sel_t byte_sel,
  output logic                      addr_out_en,  // phases 1..4
  output logic                      flag_out_en,  // phase 5
  output logic                      capture_en,   // phases 6..9
  output logic                      step          // phase 0, not in the first frame
);

  localparam bus_bridge_pkg::phase_t PH_LAST = bus_bridge_pkg::phase_t'(`FRAME_PHASES - 1);
  localparam bus_bridge_pkg::phase_t PH_OUT  = 4'd1;  // first address byte
  localparam bus_bridge_pkg::phase_t PH_FLAG = 4'd5;
  localparam bus_bridge_pkg::phase_t PH_CAP  = 4'd6;  // first read byte

  bus_bridge_pkg::phase_t phase;
  logic                   started;  // a full frame has run since reset

  always_ff @(posedge clk) begin
    if (reset) begin
      phase   <= '0;
      started <= 1'b0;
    end else begin
      if (phase == PH_LAST) begin
        phase   <= '0;
        started <= 1'b1;
      end else begin
        phase <= phase + 4'd1;
      end
    end
  end

  // strobes straight from the phase
  assign addr_out_en = (phase >= PH_OUT) && (phase < PH_FLAG);
  assign flag_out_en = (phase == PH_FLAG);
  assign capture_en  = (phase >= PH_CAP);
  assign step        = (phase == '0) && started;

  // byte lane for the output and capture phases
  always_comb begin
    byte_sel = '0;
    if (addr_out_en) begin
      byte_sel = bus_bridge_pkg::byte_sel_t'(phase - PH_OUT);
    end else if (capture_en) begin
      byte_sel = bus_bridge_pkg::byte_sel_t'(phase - PH_CAP);
    end
  end

endmodule

// File: src/addr_data_serializer.sv
// drives the registered pin outputs with address bytes, write data bytes and the write flag
`timescale 1ns/1ns
`include "bus_bridge_settings.svh"

module addr_data_serializer (
  input  logic                      clk,
  input  logic                      reset,
  cpu_bus_if.bridge                 bus,
  input  bus_bridge_pkg::byte_sel_t byte_sel,
  input  logic                      addr_out_en,
  input  logic                      flag_out_en,
  output bus_bridge_pkg::pin_byte_t uo_out,
  output bus_bridge_pkg::pin_byte_t uio_out,
  output bus_bridge_pkg::pin_byte_t uio_oe
);

  bus_bridge_pkg::pin_byte_t addr_byte;
  bus_bridge_pkg::pin_byte_t data_byte;

  // current lane of the held transaction
  always_comb begin
    addr_byte = bus.addr[byte_sel*`PIN_WIDTH +: `PIN_WIDTH];
    data_byte = bus.wdata[byte_sel*`PIN_WIDTH +: `PIN_WIDTH];
    if (!bus.write) begin
      data_byte = '0;  // reads keep uio quiet
    end
  end

  // outputs show a phase's byte in the cycle after it
  always_ff @(posedge clk) begin
    if (reset) begin
      uo_out  <= '0;
      uio_out <= '0;
      uio_oe  <= '0;
    end else if (addr_out_en) begin
      uo_out  <= addr_byte;
      uio_out <= data_byte;
      // uio turns to output only while write bytes are shown
      uio_oe  <= {`PIN_WIDTH{bus.write}};
    end else if (flag_out_en) begin
      uo_out  <= bus_bridge_pkg::pin_byte_t'(bus.write);  // 1 = write
      uio_out <= '0;
      uio_oe  <= '0;
    end else begin
      // read and step phases
      uo_out  <= '0;
      uio_out <= '0;
      uio_oe  <= '0;
    end
  end

endmodule

// File: src/read_word_assembler.sv
// collects the four read bytes from the bidirectional pins into the cpu read word
`timescale 1ns/1ns
`include "bus_bridge_settings.svh"

module read_word_assembler (
  input  logic                      clk,
  input  logic                      reset,
  cpu_bus_if.bridge                 bus,
  input  bus_bridge_pkg::byte_sel_t byte_sel,
  input  logic                      capture_en,
  input  bus_bridge_pkg::pin_byte_t uio_in
);

  // lane 0 arrives first, so the word builds up little endian
  always_ff @(posedge clk) begin
    if (reset) begin
      bus.rdata <= '0;
    end else if (capture_en) begin
      bus.rdata[byte_sel*`PIN_WIDTH +: `PIN_WIDTH] <= uio_in;
    end
  end

endmodule

// File: src/cpu_core.sv
// accumulator cpu that presents one bus transaction per frame and advances on step
`timescale 1ns/1ns
`include "bus_bridge_settings.svh"

module cpu_core (
  input  logic   clk,
  input  logic   reset,
  cpu_bus_if.cpu bus
);

  bus_bridge_pkg::word_t      pc;
  bus_bridge_pkg::word_t      acc;
  bus_bridge_pkg::word_t      store_addr;  // target of the pending sta
  bus_bridge_pkg::cpu_state_e state;

  logic [3:0]            opcode;
  bus_bridge_pkg::word_t imm;

  // decode straight off the read word
  assign opcode = bus.rdata[bus_bridge_pkg::OPCODE_MSB:bus_bridge_pkg::OPCODE_LSB];
  assign imm    = bus_bridge_pkg::word_t'(bus.rdata[bus_bridge_pkg::IMM_WIDTH-1:0]);

  // transaction follows the state, so it is steady between steps
  assign bus.write = (state == bus_bridge_pkg::CPU_STORE);
  assign bus.addr  = bus.write ? store_addr : pc;
  assign bus.wdata = acc;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc    <= bus_bridge_pkg::word_t'(`RESET_PC);
      acc   <= '0;
      state <= bus_bridge_pkg::CPU_FETCH;
    end else if (bus.step) begin
      if (state == bus_bridge_pkg::CPU_STORE) begin
        // write done, resume after the sta
        state <= bus_bridge_pkg::CPU_FETCH;
        pc    <= pc + 1'b1;
      end else begin
        case (opcode)
          bus_bridge_pkg::OP_LDI: begin
            acc <= imm;
            pc  <= pc + 1'b1;
          end
          bus_bridge_pkg::OP_ADDI: begin
            acc <= acc + imm;
            pc  <= pc + 1'b1;
          end
          bus_bridge_pkg::OP_STA: begin
            state <= bus_bridge_pkg::CPU_STORE;  // pc moves on after the write
          end
          bus_bridge_pkg::OP_JMP: begin
            pc <= imm;
          end
          default: begin
            pc <= pc + 1'b1;  // no-op
          end
        endcase
      end
    end
  end

  // store address only matters in CPU_STORE
  always_ff @(posedge clk) begin
    if (bus.step && (state == bus_bridge_pkg::CPU_FETCH) &&
        (opcode == bus_bridge_pkg::OP_STA)) begin
      store_addr <= imm;
    end
  end

endmodule

// File: src/bus_bridge_top.sv
// top level of the pin multiplexed bus bridge with the cpu, memory sits outside on the pins
`timescale 1ns/1ns

module bus_bridge_top (
  input  logic                      clk,
  input  logic                      reset,
  input  bus_bridge_pkg::pin_byte_t uio_in,   // read bytes from memory
  output bus_bridge_pkg::pin_byte_t uo_out,   // address bytes, then write flag
  output bus_bridge_pkg::pin_byte_t uio_out,  // write data bytes
  output bus_bridge_pkg::pin_byte_t uio_oe    // all ones while driving uio
);

  bus_bridge_pkg::byte_sel_t byte_sel;
  logic                      addr_out_en;
  logic                      flag_out_en;
  logic                      capture_en;
  logic                      step;

  cpu_bus_if bus ();

  assign bus.step = step;

  bus_phase_ctrl u_ctrl (
    .clk         (clk),
    .reset       (reset),
    .byte_sel    (byte_sel),
    .addr_out_en (addr_out_en),
    .flag_out_en (flag_out_en),
    .capture_en  (capture_en),
    .step        (step)
  );

  addr_data_serializer u_serializer (
    .clk         (clk),
    .reset       (reset),
    .bus         (bus.bridge),
    .byte_sel    (byte_sel),
    .addr_out_en (addr_out_en),
    .flag_out_en (flag_out_en),
    .uo_out      (uo_out),
    .uio_out     (uio_out),
    .uio_oe      (uio_oe)
  );

  read_word_assembler u_assembler (
    .clk        (clk),
    .reset      (reset),
    .bus        (bus.bridge),
    .byte_sel   (byte_sel),
    .capture_en (capture_en),
    .uio_in     (uio_in)
  );

  cpu_core u_cpu (
    .clk   (clk),
    .reset (reset),
    .bus   (bus.cpu)
  );

endmodule

// File: tb/tb_bus_bridge.sv
// self-checking testbench for bus_bridge_top, acts as the external memory on the pins
`timescale 1ns/1ns
`include "bus_bridge_settings.svh"

module tb_bus_bridge;

  localparam int MEM_WORDS   = 64;
  localparam int PROG_LEN    = 11;
  localparam int NUM_FRAMES  = 13;
  localparam int RESET_CYCLES = 8;
  localparam int CYCLE_LIMIT = NUM_FRAMES * `FRAME_PHASES + 40;
  localparam logic [3:0] OP_NOP = 4'hC;  // any unused opcode

  logic                  clk;
  logic                  reset;
  logic [`PIN_WIDTH-1:0] uio_in;
  logic [`PIN_WIDTH-1:0] uo_out;
  logic [`PIN_WIDTH-1:0] uio_out;
  logic [`PIN_WIDTH-1:0] uio_oe;

  logic [`BUS_WIDTH-1:0] mem [MEM_WORDS];
  logic [`BUS_WIDTH-1:0] prog_addr [PROG_LEN];
  logic [`BUS_WIDTH-1:0] prog_word [PROG_LEN];
  logic [31:0]           rng;
  int                    cycle_count = 0;

  // expected transaction per frame, write data is 0 on reads
  logic [`BUS_WIDTH-1:0] exp_addr [NUM_FRAMES] = '{
    32'h00, 32'h01, 32'h02, 32'h20, 32'h03, 32'h04, 32'h21,
    32'h05, 32'h10, 32'h11, 32'h22, 32'h12, 32'h00
  };
  logic exp_write [NUM_FRAMES] = '{0, 0, 0, 1, 0, 0, 1, 0, 0, 0, 1, 0, 0};
  logic [`BUS_WIDTH-1:0] exp_data [NUM_FRAMES] = '{
    32'h0, 32'h0, 32'h0, 32'h0001_2E01, 32'h0, 32'h0, 32'h0001_2E01,
    32'h0, 32'h0, 32'h0, 32'h0001_2E02, 32'h0, 32'h0
  };

  bus_bridge_top DUT (
    .clk     (clk),
    .reset   (reset),
    .uio_in  (uio_in),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the bus frames did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Regression failed");
      $fatal(1);
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] make_instr(input logic [3:0] op, input logic [27:0] imm);
    return {op, imm};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
      $display("Regression failed");
      $fatal(1);
    end
  endtask

  task automatic check_outputs_idle();
    check_value("uo_out", uo_out, 32'h0);
    check_value("uio_out", uio_out, 32'h0);
    check_value("uio_oe", uio_oe, 32'h0);
  endtask

  // padding no-op with random upper immediate bits
  task automatic next_pad_word(output logic [31:0] word);
    rng  = xorshift32(rng);
    word = make_instr(OP_NOP, {rng[31:20], 16'h0000});
  endtask

  task automatic load_program();
    logic [31:0] pad;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {4'hF, 28'(i) ^ 28'h5A5_0000};  // no-op, unique per address
    end
    prog_addr[0]  = 32'h00;
    prog_word[0]  = make_instr(bus_bridge_pkg::OP_LDI, 28'h0012345);
    prog_addr[1]  = 32'h01;
    prog_word[1]  = make_instr(bus_bridge_pkg::OP_ADDI, 28'h0000ABC);
    prog_addr[2]  = 32'h02;
    prog_word[2]  = make_instr(bus_bridge_pkg::OP_STA, 28'h20);
    next_pad_word(pad);
    prog_addr[3]  = 32'h03;
    prog_word[3]  = pad;  // executed no-op
    prog_addr[4]  = 32'h04;
    prog_word[4]  = make_instr(bus_bridge_pkg::OP_STA, 28'h21);
    prog_addr[5]  = 32'h05;
    prog_word[5]  = make_instr(bus_bridge_pkg::OP_JMP, 28'h10);
    next_pad_word(pad);
    prog_addr[6]  = 32'h06;
    prog_word[6]  = pad;  // skipped by the jump
    next_pad_word(pad);
    prog_addr[7]  = 32'h07;
    prog_word[7]  = pad;
    prog_addr[8]  = 32'h10;
    prog_word[8]  = make_instr(bus_bridge_pkg::OP_ADDI, 28'h1);
    prog_addr[9]  = 32'h11;
    prog_word[9]  = make_instr(bus_bridge_pkg::OP_STA, 28'h22);
    prog_addr[10] = 32'h12;
    prog_word[10] = make_instr(bus_bridge_pkg::OP_JMP, 28'h0);
    for (int i = 0; i < PROG_LEN; i++) begin
      mem[prog_addr[i]] = prog_word[i];
    end
  endtask

  task automatic read_memory(input logic [31:0] addr, output logic [31:0] word);
    if (addr >= MEM_WORDS) begin
      $display("Error at %0t ns: address 0x%08h lies outside the memory model", $time, addr);
      $display("Regression failed");
      $fatal(1);
    end
    word = mem[addr];
  endtask

  // one ten cycle frame, sampled at negedge and driven at posedge
  task automatic run_frame(input int f);
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rd_word;
    addr    = '0;
    wdata   = '0;
    rd_word = '0;
    for (int p = 0; p < `FRAME_PHASES; p++) begin
      @(negedge clk);
      // outputs lag the phase by one cycle
      if (p >= 2 && p <= 5) begin
        addr[(p-2)*`PIN_WIDTH +: `PIN_WIDTH]  = uo_out;
        wdata[(p-2)*`PIN_WIDTH +: `PIN_WIDTH] = uio_out;
        check_value("uio_oe", uio_oe, exp_write[f] ? 32'hFF : 32'h0);
        if (p == 5) begin
          check_value("address", addr, exp_addr[f]);
          check_value("uio_out write data", wdata, exp_data[f]);
          if (!exp_write[f]) begin
            read_memory(addr, rd_word);
          end
        end
      end else if (p == 6) begin
        check_value("uo_out write flag", uo_out, {31'd0, exp_write[f]});
        check_value("uio_out", uio_out, 32'h0);
        check_value("uio_oe", uio_oe, 32'h0);
        if (exp_write[f]) begin
          mem[addr] = wdata;
        end
      end else begin
        check_outputs_idle();
      end
      @(posedge clk);
      if (p >= 5 && p <= 8) begin
        uio_in <= rd_word[(p-5)*`PIN_WIDTH +: `PIN_WIDTH];  // read byte for phase p+1
      end else begin
        uio_in <= '0;
      end
    end
  endtask

  initial begin
    reset  = 1'b1;
    uio_in = '0;
    rng    = 32'd62;
    load_program();
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(negedge clk);
      check_outputs_idle();
      @(posedge clk);
      if (i == RESET_CYCLES - 1) begin
        reset <= 1'b0;  // phase 0 of the first frame follows
      end
    end
    for (int f = 0; f < NUM_FRAMES; f++) begin
      run_frame(f);
    end
    $display("Regression passed");
    $finish;
  end

endmodule

// File: build.f
+incdir+include
src/bus_bridge_pkg.sv
src/cpu_bus_if.sv
src/bus_phase_ctrl.sv
src/addr_data_serializer.sv
src/read_word_assembler.sv
src/cpu_core.sv
src/bus_bridge_top.sv
tb/tb_bus_bridge.sv

// File: Bender.yml
package:
  name: bus_bridge

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/bus_bridge_pkg.sv
      - src/cpu_bus_if.sv
      - src/bus_phase_ctrl.sv
      - src/addr_data_serializer.sv
      - src/read_word_assembler.sv
      - src/cpu_core.sv
      - src/bus_bridge_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tb/tb_bus_bridge.sv
